// ==== fp_add_cases.txt ====
# group(dec) sub rnd in_1 in_2 res flags, all hex after the group
# rnd 0 rne 1 rtz 2 rdn 3 rup 4 rmm, flags nv dz of uf nx, group 5 back-to-back
1 0 0 3f800000 40000000 40400000 00
1 0 1 3f800000 40000000 40400000 00
1 1 0 40400000 3f800000 40000000 00
1 1 2 3fc00000 3f000000 3f800000 00
1 0 3 c0000000 3f800000 bf800000 00
1 0 4 40400000 3fc00000 40900000 00
1 1 1 3f800000 40400000 c0000000 00
2 0 0 3f800000 33800000 3f800000 01
2 0 4 3f800000 33800000 3f800001 01
2 0 0 3f800001 33800000 3f800002 01
2 0 4 3f800000 33000000 3f800000 01
2 0 3 3f800000 33000000 3f800001 01
2 1 3 bf800000 33800000 bf800000 01
2 1 2 bf800000 33800000 bf800001 01
2 0 0 3dcccccd 3e4ccccd 3e99999a 01
2 0 1 3dcccccd 3e4ccccd 3e999999 01
2 0 0 3fffffff 33800000 40000000 01
3 0 0 7fc00000 3f800000 7fc00000 00
3 0 1 ffc12345 40000000 7fc00000 00
3 0 0 7f800001 3f800000 7fc00000 10
3 1 0 7f800000 7f800000 7fc00000 10
3 0 2 ff800000 7f800000 7fc00000 10
3 0 0 7f800000 3f800000 7f800000 00
3 1 0 3f800000 7f800000 ff800000 00
4 0 0 7f7fffff 7f7fffff 7f800000 05
4 0 1 7f7fffff 7f7fffff 7f7fffff 05
4 0 2 ff7fffff ff7fffff ff800000 05
4 0 3 ff7fffff ff7fffff ff7fffff 05
4 1 0 40490fdb 40490fdb 00000000 00
4 1 2 40490fdb 40490fdb 80000000 00
4 0 0 80000000 80000000 80000000 00
4 0 0 00000001 00000001 00000002 00
4 0 0 00400000 00400000 00800000 00
4 1 0 00800000 00000001 007fffff 00
5 0 0 3f800000 40000000 40400000 00
5 0 1 7f7fffff 7f7fffff 7f7fffff 05
5 0 0 7f800001 3f800000 7fc00000 10
5 0 0 80000000 80000000 80000000 00
5 0 4 3f800000 33800000 3f800001 01

// ==== all.f ====
fp_add_pkg.sv
fp_operand_unpack.sv
fp_align_add.sv
fp_normalize_round.sv
fp_add_sub.sv
fp_add_sub_sva.sv
tb_fp_add_sub.sv

// ==== run.sh ====
#!/bin/bash
# build and run the fp_add_sub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fp_add_sub -f all.f -o sim_fp_add_sub
./obj_dir/sim_fp_add_sub +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1

// ==== tb_fp_add_sub.sv ====
// testbench for the binary32 add/subtract pipeline
// reads operands and expected results from fp_add_cases.txt,
// drives on the falling edge with random tags and idle gaps,
// checks result, flags and tag of every valid against a queue
module tb_fp_add_sub;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int burst_group = 5;	// starts on consecutive cycles
	localparam int valid_timeout = 20;

	logic                   clk;
	logic                   reset;
	logic                   start;
	logic                   sub;
	fp_add_pkg::rnd_mode_t  rnd;
	fp_add_pkg::fp_word_t   in_1;
	fp_add_pkg::fp_word_t   in_2;
	fp_add_pkg::tag_t       rd;
	logic                   valid;
	fp_add_pkg::fp_word_t   res;
	fp_add_pkg::fp_flags_t  exceptions;
	fp_add_pkg::tag_t       rd_out;

	// expectations of the operations in flight with the oldest first
	fp_add_pkg::fp_word_t   exp_res_q[$];
	fp_add_pkg::fp_flags_t  exp_flags_q[$];
	fp_add_pkg::tag_t       exp_tag_q[$];

	logic [31:0] rng_state = 32'hca77;
	int          errors = 0;
	int          checked = 0;
	logic        timed_out = 1'b0;

	fp_add_sub dut0 (
		.clk(clk), .reset(reset), .start(start), .sub(sub), .rnd(rnd),
		.in_1(in_1), .in_2(in_2), .rd(rd),
		.valid(valid), .res(res), .exceptions(exceptions), .rd_out(rd_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_res(input fp_add_pkg::fp_word_t expected,
		input fp_add_pkg::fp_word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: res expected %h, got %h", $time, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flags(input fp_add_pkg::fp_flags_t expected,
		input fp_add_pkg::fp_flags_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: exceptions expected %b, got %b", $time, expected, actual);
			errors++;
		end
	endtask

	task automatic check_tag(input fp_add_pkg::tag_t expected, input fp_add_pkg::tag_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: rd_out expected %h, got %h", $time, expected, actual);
			errors++;
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	task automatic next_cycle();
		fp_add_pkg::fp_word_t  r;
		fp_add_pkg::fp_flags_t f;
		fp_add_pkg::tag_t      t;
		@(negedge clk);
		if (valid === 1'b1) begin
			if (exp_res_q.size() == 0) begin
				$display("ERROR at %0t: valid high with no operation pending", $time);
				errors++;
			end else begin
				r = exp_res_q.pop_front();
				f = exp_flags_q.pop_front();
				t = exp_tag_q.pop_front();
				check_res(r, res);
				check_flags(f, exceptions);
				check_tag(t, rd_out);
				checked++;
			end
		end
		start = 1'b0;	// one-cycle strobe
	endtask

	task automatic apply_case(input logic s, input fp_add_pkg::rnd_mode_t m,
		input fp_add_pkg::fp_word_t a, input fp_add_pkg::fp_word_t b,
		input fp_add_pkg::fp_word_t r, input fp_add_pkg::fp_flags_t f);
		fp_add_pkg::tag_t tag;
		rng_state = xorshift(rng_state);
		tag = rng_state[fp_add_pkg::tag_w-1:0];
		next_cycle();
		start = 1'b1;
		sub = s;
		rnd = m;
		in_1 = a;
		in_2 = b;
		rd = tag;
		exp_res_q.push_back(r);
		exp_flags_q.push_back(f);
		exp_tag_q.push_back(tag);
	endtask

	// wait for the pipeline to empty or for valid_timeout cycles
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_res_q.size() != 0 && waited < valid_timeout) begin
			next_cycle();
			waited++;
		end
		if (exp_res_q.size() != 0) begin
			$display("ERROR at %0t: no valid within timeout, %0d operations pending",
				$time, exp_res_q.size());
			errors++;
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int          fd, grp, cur_group, gap, group_errors, group_cases;
		logic [31:0] f_sub, f_rnd, f_a, f_b, f_res, f_flags;
		string       line;

		reset = 1'b1;
		start = 1'b0;
		sub = 1'b0;
		rnd = fp_add_pkg::rnd_rne;
		in_1 = '0;
		in_2 = '0;
		rd = '0;
		cur_group = -1;
		group_errors = 0;
		group_cases = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		fd = $fopen("fp_add_cases.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open fp_add_cases.txt");
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				// comment and blank lines do not parse
				if ($sscanf(line, "%d %h %h %h %h %h %h", grp, f_sub, f_rnd, f_a, f_b,
					f_res, f_flags) == 7) begin
					if (grp != cur_group) begin
						if (cur_group >= 0) begin
							drain();
							$display("group %0d done: %0d cases, %0d errors", cur_group,
								group_cases, errors - group_errors);
						end
						cur_group = grp;
						group_errors = errors;
						group_cases = 0;
					end
					if (grp != burst_group) begin
						rng_state = xorshift(rng_state);
						gap = int'(rng_state % 3);
						repeat (gap) next_cycle();
					end
					apply_case(f_sub[0], fp_add_pkg::rnd_mode_t'(f_rnd[2:0]), f_a, f_b,
						f_res, f_flags[4:0]);
					group_cases++;
				end
			end
			$fclose(fd);
			if (cur_group >= 0 && !timed_out) begin
				drain();
				$display("group %0d done: %0d cases, %0d errors", cur_group,
					group_cases, errors - group_errors);
			end
		end

		errors += dut0.sva0.fails;
		$display("summary: %0d results checked, %0d errors", checked, errors);
		if (errors == 0 && !timed_out) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== fp_add_sub_sva.sv ====
// assertions on the adder's valid timing and exception flags
// bound into every fp_add_sub instance
module fp_add_sub_sva (
	input logic                   clk,
	input logic                   reset,
	input logic                   start,
	input logic                   valid,
	input fp_add_pkg::fp_word_t   res,
	input fp_add_pkg::fp_flags_t  exceptions
);

	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;	// failed assertions so far

	// covers the reset cycles and the one right after
	assert property (@(posedge clk) reset |=> !valid)
		else begin
			$error("valid high during or right after reset");
			fails++;
		end

	// fixed latency of one cycle
	assert property (@(posedge clk) disable iff (reset) !$past(reset) |-> valid == $past(start))
		else begin
			$error("valid does not follow start by one cycle");
			fails++;
		end

	assert property (@(posedge clk) valid |-> !exceptions[3] && !exceptions[1])
		else begin
			$error("divide-by-zero or underflow flag set");
			fails++;
		end

	assert property (@(posedge clk) valid && exceptions[4] |-> res == fp_add_pkg::qnan_word)
		else begin
			$error("invalid flag without the canonical quiet NaN");
			fails++;
		end

endmodule

bind fp_add_sub fp_add_sub_sva sva0 (
	.clk(clk), .reset(reset), .start(start), .valid(valid),
	.res(res), .exceptions(exceptions)
);

// ==== fp_add_sub.sv ====
// binary32 add/subtract, one register stage
// two operand unpack lanes, align/add stage, normalise/round stage
module fp_add_sub (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      sub,
	input  fp_add_pkg::rnd_mode_t     rnd,
	input  fp_add_pkg::fp_word_t      in_1,
	input  fp_add_pkg::fp_word_t      in_2,
	input  fp_add_pkg::tag_t          rd,
	output logic                      valid,
	output fp_add_pkg::fp_word_t      res,
	output fp_add_pkg::fp_flags_t     exceptions,
	output fp_add_pkg::tag_t          rd_out
);

	logic                             op_sign [2];
	logic [fp_add_pkg::exp_w-1:0]     op_exp [2];
	logic [fp_add_pkg::man_w-1:0]     op_man [2];
	logic                             op_nan [2];
	logic                             op_snan [2];
	logic                             op_inf [2];
	logic                             op_zero [2];

	logic                             s_valid, s_sign;
	logic [fp_add_pkg::sum_w:0]       s_sum;
	logic [fp_add_pkg::exp_w-1:0]     s_exp;
	fp_add_pkg::rnd_mode_t            s_rnd;
	fp_add_pkg::tag_t                 s_tag;
	logic                             s_nan, s_nan_quiet, s_inf, s_inf_sign;
	logic                             s_zero_same_sign;

	// lane 0 is in_1, lane 1 is in_2
	for (genvar i = 0; i < 2; i++) begin : g_lane
		fp_operand_unpack unpack (
			.word(i == 0 ? in_1 : in_2),
			.sign(op_sign[i]),
			.exp(op_exp[i]),
			.man(op_man[i]),
			.is_nan(op_nan[i]),
			.is_snan(op_snan[i]),
			.is_inf(op_inf[i]),
			.is_zero(op_zero[i])
		);
	end

	fp_align_add align0 (
		.clk(clk), .reset(reset), .start(start), .sub(sub), .rnd(rnd), .rd(rd),
		.op_sign(op_sign), .op_exp(op_exp), .op_man(op_man),
		.op_nan(op_nan), .op_snan(op_snan), .op_inf(op_inf), .op_zero(op_zero),
		.s_valid(s_valid), .s_sum(s_sum), .s_sign(s_sign), .s_exp(s_exp),
		.s_rnd(s_rnd), .s_tag(s_tag), .s_nan(s_nan), .s_nan_quiet(s_nan_quiet),
		.s_inf(s_inf), .s_inf_sign(s_inf_sign), .s_zero_same_sign(s_zero_same_sign)
	);

	fp_normalize_round round0 (
		.s_sum(s_sum), .s_sign(s_sign), .s_exp(s_exp), .s_rnd(s_rnd),
		.s_nan(s_nan), .s_nan_quiet(s_nan_quiet), .s_inf(s_inf),
		.s_inf_sign(s_inf_sign), .s_zero_same_sign(s_zero_same_sign),
		.res(res), .exceptions(exceptions)
	);

	assign valid = s_valid;
	assign rd_out = s_tag;

endmodule

// ==== fp_normalize_round.sv ====
// second pipeline stage of the adder
// normalise the registered sum, round in the five modes,
// pack the binary32 result and the exception flags
module fp_normalize_round (
	input  logic [fp_add_pkg::sum_w:0]      s_sum,
	input  logic                            s_sign,
	input  logic [fp_add_pkg::exp_w-1:0]    s_exp,
	input  fp_add_pkg::rnd_mode_t           s_rnd,
	input  logic                            s_nan,
	input  logic                            s_nan_quiet,
	input  logic                            s_inf,
	input  logic                            s_inf_sign,
	input  logic                            s_zero_same_sign,
	output fp_add_pkg::fp_word_t            res,
	output fp_add_pkg::fp_flags_t           exceptions
);

	typedef logic [fp_add_pkg::exp_w-1:0] shift_t;
	typedef logic [fp_add_pkg::exp_w:0] exp_x_t;	// one spare bit for overflow

	logic [fp_add_pkg::sum_w:0]                        neg_sum;
	logic [fp_add_pkg::sum_w-1:0]                      mag;
	logic                                              shr;
	shift_t                                            lzc, shl;
	logic [fp_add_pkg::man_w-1:0]                      man_z;
	exp_x_t                                            exp_n, exp_r;
	logic [fp_add_pkg::guard_w-1:0]                    grd;
	logic                                              round_up, roverflow;
	logic [fp_add_pkg::man_w-fp_add_pkg::guard_w:0]    rounded;
	logic                                              exp_inc, calc_inf, is_zero, rsign;
	logic [fp_add_pkg::exp_w-1:0]                      exp_out;
	logic                                              nv, of, nx;

	// magnitude from the two's complement sum
	always_comb begin
		neg_sum = -s_sum;
		if (s_sum[fp_add_pkg::sum_w])
			mag = neg_sum[fp_add_pkg::sum_w-1:0];
		else
			mag = s_sum[fp_add_pkg::sum_w-1:0];
		shr = mag[fp_add_pkg::sum_w-1];	// carry out of the add
	end

	// leading zeros below the carry bit, man_w when all zero
	always_comb begin
		lzc = shift_t'(fp_add_pkg::man_w);
		for (int i = 0; i < fp_add_pkg::man_w; i++) begin
			if (mag[i])
				lzc = shift_t'(fp_add_pkg::man_w - 1 - i);
		end
	end

	always_comb begin
		shl = '0;
		if (shr) begin
			man_z = {mag[fp_add_pkg::sum_w-1:2], |mag[1:0]};	// keep sticky
			exp_n = exp_x_t'(s_exp) + exp_x_t'(1);
		end else if (lzc < s_exp) begin
			shl = lzc;
			man_z = mag[fp_add_pkg::man_w-1:0] << shl;
			exp_n = exp_x_t'(s_exp) - exp_x_t'(lzc);
		end else begin
			// can't go below exponent 1, result stays denormal
			shl = s_exp - shift_t'(1);
			man_z = mag[fp_add_pkg::man_w-1:0] << shl;
			exp_n = '0;
		end
	end

	always_comb begin
		grd = man_z[fp_add_pkg::guard_w-1:0];
		round_up = 1'b0;
		roverflow = 1'b0;	// overflow saturates to max finite
		case (s_rnd)
			fp_add_pkg::rnd_rne: round_up = grd[fp_add_pkg::guard_w-1] &&
				(grd[fp_add_pkg::guard_w-2:0] != '0 || man_z[fp_add_pkg::guard_w]);
			fp_add_pkg::rnd_rtz: roverflow = 1'b1;
			fp_add_pkg::rnd_rdn: begin
				round_up = grd != '0 && s_sign;
				roverflow = !s_sign;
			end
			fp_add_pkg::rnd_rup: begin
				round_up = grd != '0 && !s_sign;
				roverflow = s_sign;
			end
			fp_add_pkg::rnd_rmm: round_up = grd[fp_add_pkg::guard_w-1];
			default: round_up = 1'b0;
		endcase

		rounded = {1'b0, man_z[fp_add_pkg::man_w-1:fp_add_pkg::guard_w]} +
			{{(fp_add_pkg::man_w-fp_add_pkg::guard_w){1'b0}}, round_up};

		// mantissa carry, or a denormal that rounded up into the hidden bit
		exp_inc = rounded[fp_add_pkg::man_w-fp_add_pkg::guard_w] ||
			(exp_n == '0 && rounded[fp_add_pkg::man_w-fp_add_pkg::guard_w-1]);
		exp_r = exp_n + exp_x_t'(exp_inc);
		calc_inf = exp_r >= exp_x_t'(fp_add_pkg::exp_max);

		is_zero = rounded == '0;
		exp_out = is_zero ? '0 : exp_r[fp_add_pkg::exp_w-1:0];
		if (is_zero)
			rsign = s_zero_same_sign ? s_sign : (s_rnd == fp_add_pkg::rnd_rdn);
		else
			rsign = s_sign;
	end

	always_comb begin
		nv = 1'b0;
		of = 1'b0;
		nx = (calc_inf || grd != '0) && !s_inf && !s_nan;
		if (s_nan) begin
			nv = !s_nan_quiet;
			res = fp_add_pkg::qnan_word;
		end else if (!s_inf && calc_inf && roverflow) begin
			of = 1'b1;
			res = {s_sign, fp_add_pkg::exp_max[fp_add_pkg::exp_w-1:1], 1'b0,
				{fp_add_pkg::frac_w{1'b1}}};
		end else if (s_inf || calc_inf) begin
			of = calc_inf && !s_inf;
			res = {s_inf ? s_inf_sign : s_sign, fp_add_pkg::exp_max,
				{fp_add_pkg::frac_w{1'b0}}};
		end else begin
			res = {rsign, exp_out, rounded[fp_add_pkg::frac_w-1:0]};
		end
	end

	assign exceptions = {nv, 1'b0, of, 1'b0, nx};	// no dz or uf from an add

endmodule

// ==== fp_align_add.sv ====
// first pipeline stage of the adder
// aligns the smaller operand, does the signed mantissa add,
// forms the special case bits and registers it all with tag and valid
module fp_align_add (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic                               sub,
	input  fp_add_pkg::rnd_mode_t              rnd,
	input  fp_add_pkg::tag_t                   rd,
	input  logic                               op_sign [2],
	input  logic [fp_add_pkg::exp_w-1:0]       op_exp [2],
	input  logic [fp_add_pkg::man_w-1:0]       op_man [2],
	input  logic                               op_nan [2],
	input  logic                               op_snan [2],
	input  logic                               op_inf [2],
	input  logic                               op_zero [2],
	output logic                               s_valid,
	output logic [fp_add_pkg::sum_w:0]         s_sum,
	output logic                               s_sign,
	output logic [fp_add_pkg::exp_w-1:0]       s_exp,
	output fp_add_pkg::rnd_mode_t              s_rnd,
	output fp_add_pkg::tag_t                   s_tag,
	output logic                               s_nan,
	output logic                               s_nan_quiet,
	output logic                               s_inf,
	output logic                               s_inf_sign,
	output logic                               s_zero_same_sign
);

	logic                             sign_1, sign_2, sign_x;
	logic                             exp_ge, bad_inf;
	logic [fp_add_pkg::exp_w-1:0]     big_exp, diff;
	logic [fp_add_pkg::man_w-1:0]     shift_in, shifted, man_1, man_2;
	logic [2*fp_add_pkg::man_w-1:0]   wide;
	logic [fp_add_pkg::sum_w:0]       ext_1, ext_2, sum;

	assign sign_1 = op_sign[0];
	assign sign_2 = op_sign[1] ^ (sub & ~op_nan[1]);	// a NaN keeps its sign

	// align the smaller exponent, lost bits fold into sticky
	always_comb begin
		exp_ge = op_exp[0] >= op_exp[1];
		if (exp_ge) begin
			big_exp = op_exp[0];
			diff = op_exp[0] - op_exp[1];
			shift_in = op_man[1];
		end else begin
			big_exp = op_exp[1];
			diff = op_exp[1] - op_exp[0];
			shift_in = op_man[0];
		end
		wide = {shift_in, {fp_add_pkg::man_w{1'b0}}} >> diff;
		if (int'(diff) > fp_add_pkg::man_w)
			shifted = {{(fp_add_pkg::man_w-1){1'b0}}, |shift_in};	// all of it is sticky
		else
			shifted = {wide[2*fp_add_pkg::man_w-1:fp_add_pkg::man_w+1],
				wide[fp_add_pkg::man_w] | (|wide[fp_add_pkg::man_w-1:0])};
		man_1 = exp_ge ? op_man[0] : shifted;
		man_2 = exp_ge ? shifted : op_man[1];
	end

	// both negative: add magnitudes and mark the sign
	// otherwise negate the negative one and let the sum carry the sign
	always_comb begin
		sign_x = sign_1 & sign_2;
		ext_1 = {2'b0, man_1};
		ext_2 = {2'b0, man_2};
		if (sign_1 && !sign_2)
			ext_1 = -ext_1;
		if (sign_2 && !sign_1)
			ext_2 = -ext_2;
		sum = ext_1 + ext_2;
	end

	assign bad_inf = op_inf[0] && op_inf[1] && (sign_1 != sign_2);	// inf - inf

	always_ff @(posedge clk) begin
		if (reset)
			s_valid <= 1'b0;
		else
			s_valid <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			s_sum <= sum;
			s_sign <= sign_x ^ sum[fp_add_pkg::sum_w];
			s_exp <= big_exp;
			s_rnd <= rnd;
			s_tag <= rd;
			s_nan <= op_nan[0] || op_nan[1] || bad_inf;
			s_nan_quiet <= !(op_snan[0] || op_snan[1] || bad_inf);
			s_inf <= op_inf[0] || op_inf[1];
			s_inf_sign <= (op_inf[0] & sign_1) | (op_inf[1] & sign_2);
			s_zero_same_sign <= op_zero[0] && op_zero[1] && (sign_1 == sign_2);
		end
	end

endmodule

// ==== fp_operand_unpack.sv ====
// binary32 operand unpack
// sign, effective exponent, mantissa with hidden and guard bits
// and the NaN / signalling NaN / infinity / zero class bits
module fp_operand_unpack (
	input  fp_add_pkg::fp_word_t                word,
	output logic                                sign,
	output logic [fp_add_pkg::exp_w-1:0]        exp,
	output logic [fp_add_pkg::man_w-1:0]        man,
	output logic                                is_nan,
	output logic                                is_snan,
	output logic                                is_inf,
	output logic                                is_zero
);

	logic [fp_add_pkg::exp_w-1:0]  raw_exp;
	logic [fp_add_pkg::frac_w-1:0] frac;
	logic                          exp_ones, exp_zero, frac_zero;

	assign raw_exp = word[fp_add_pkg::frac_w +: fp_add_pkg::exp_w];
	assign frac = word[fp_add_pkg::frac_w-1:0];
	assign sign = word[fp_add_pkg::exp_w+fp_add_pkg::frac_w];

	assign exp_ones = raw_exp == fp_add_pkg::exp_max;
	assign exp_zero = raw_exp == '0;
	assign frac_zero = frac == '0;

	// denormals sit at exponent 1 with no hidden bit
	assign exp = exp_zero ? {{(fp_add_pkg::exp_w-1){1'b0}}, 1'b1} : raw_exp;
	assign man = {!exp_zero, frac, {fp_add_pkg::guard_w{1'b0}}};

	assign is_nan = exp_ones && !frac_zero;
	assign is_snan = is_nan && !frac[fp_add_pkg::frac_w-1];	// quiet bit clear
	assign is_inf = exp_ones && frac_zero;
	assign is_zero = exp_zero && frac_zero;

endmodule

// ==== fp_add_pkg.sv ====
// shared definitions for the binary32 adder
// field widths, mantissa and sum widths, tag width
// word, flag and tag types, rounding mode encoding
package fp_add_pkg;

	localparam int exp_w   = 8;
	localparam int frac_w  = 23;
	localparam int guard_w = 3;	// guard, round, sticky
	localparam int man_w   = 1 + frac_w + guard_w;	// hidden bit on top
	localparam int sum_w   = man_w + 1;	// room for the carry

	localparam logic [exp_w-1:0] exp_max = '1;

	localparam int tag_w = 6;

	typedef logic [exp_w+frac_w:0] fp_word_t;

	// invalid, div by zero, overflow, underflow, inexact
	typedef logic [4:0] fp_flags_t;

	typedef logic [tag_w-1:0] tag_t;

	// RISC-V rm field encoding
	typedef enum logic [2:0] {
		rnd_rne = 3'd0,	// nearest, ties to even
		rnd_rtz = 3'd1,
		rnd_rdn = 3'd2,	// towards -inf
		rnd_rup = 3'd3,	// towards +inf
		rnd_rmm = 3'd4	// nearest, ties away
	} rnd_mode_t;

	// canonical quiet NaN, positive with only the top fraction bit set
	localparam fp_word_t qnan_word = {1'b0, exp_max, 1'b1, {(frac_w-1){1'b0}}};

endpackage
